// ==== spi_frame_pkg.sv ====
package spi_frame_pkg;

    // frame sequencer states, one transfer per fs level.
    typedef enum logic [3:0] {
        IDLE    = 4'd0,
        WAIT_FS = 4'd1,
        START   = 4'd2,
        SHIFT   = 4'd3,
        TAIL    = 4'd4,
        STOP    = 4'd5,
        GAP     = 4'd6,
        DONE    = 4'd7
    } seq_state_t;

    // four system clocks make one sclk period.
    typedef enum logic [1:0] {
        PH_DRIVE = 2'd0, // mosi changes here.
        PH_RISE  = 2'd1,
        PH_HIGH  = 2'd2,
        PH_FALL  = 2'd3
    } phase_t;

endpackage

// ==== spi_strobe_if.sv ====
`timescale 1ns/10ps

interface spi_strobe_if
    import spi_frame_pkg::*;
#(
    parameter int WIDTH = 16
);

    phase_t                     phase;   // position inside the current bit.
    logic [$clog2(WIDTH)-1:0]   bit_cnt; // bit index, 0 is the msb.

    logic frame_start;
    logic drive_bit;
    logic sclk_rise;
    logic sclk_fall;
    logic sample_a;
    logic sample_b;
    logic latch;
    logic frame_stop;
    logic clear;

    modport ctrl (
        output phase, bit_cnt,
        output frame_start, drive_bit, sclk_rise, sclk_fall,
        output sample_a, sample_b, latch, frame_stop, clear
    );

    modport line (input frame_start, drive_bit, sclk_rise, sclk_fall, frame_stop, clear);

    modport capture (input clear, sample_a, sample_b, latch);

endinterface

// ==== spi_frame_ctrl.sv ====
`timescale 1ns/10ps

module spi_frame_ctrl
    import spi_frame_pkg::*;
#(
    parameter int WIDTH      = 16,
    parameter int GAP_CYCLES = 10
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       fs,
    spi_strobe_if.ctrl strobes,
    output logic       cs,
    output logic       fd_spi,
    output logic       fd_prd,
    output logic       idle
);

    localparam int BW = $clog2(WIDTH);
    localparam int GW = (GAP_CYCLES > 1) ? $clog2(GAP_CYCLES) : 1;
    localparam logic [BW-1:0] LAST_BIT = BW'(WIDTH - 1);
    localparam logic [GW-1:0] LAST_GAP = GW'(GAP_CYCLES - 1);

    seq_state_t    state;
    seq_state_t    next_state;
    logic [GW-1:0] gap_cnt;
    logic          in_shift;
    logic          in_tail;
    logic          phase_end;

    assign in_shift  = (state == SHIFT);
    assign in_tail   = (state == TAIL);
    assign phase_end = (strobes.phase == PH_FALL);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    next_state = WAIT_FS;
            WAIT_FS: if (fs) next_state = START;
            START:   next_state = SHIFT;
            SHIFT:   if (phase_end && strobes.bit_cnt == LAST_BIT) next_state = TAIL;
            TAIL:    if (phase_end) next_state = STOP;
            STOP:    next_state = GAP;
            GAP:     if (gap_cnt == LAST_GAP) next_state = DONE;
            DONE:    if (!fs) next_state = WAIT_FS; // hold until fs drops.
            default: next_state = IDLE;
        endcase
    end

    // phase runs through shift and tail, bit index only advances in shift.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            strobes.phase   <= PH_DRIVE;
            strobes.bit_cnt <= '0;
        end else if (in_shift || in_tail) begin
            strobes.phase <= phase_t'(strobes.phase + 2'd1);
            if (in_shift && phase_end) begin
                strobes.bit_cnt <= strobes.bit_cnt + 1'b1;
            end
        end else begin
            strobes.phase   <= PH_DRIVE;
            strobes.bit_cnt <= '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gap_cnt <= '0;
        end else if (state == GAP) begin
            gap_cnt <= gap_cnt + 1'b1;
        end else begin
            gap_cnt <= '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs <= 1'b1;
        end else if (state == IDLE || state == STOP) begin
            cs <= 1'b1;
        end else if (state == START) begin
            cs <= 1'b0;
        end
    end

    // raised with cs, dropped one edge into done.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fd_spi <= 1'b0;
        end else if (state == IDLE || state == WAIT_FS || state == DONE) begin
            fd_spi <= 1'b0;
        end else if (state == STOP) begin
            fd_spi <= 1'b1;
        end
    end

    assign fd_prd = (state == DONE);
    assign idle   = (state == IDLE);

    assign strobes.frame_start = (state == START);
    assign strobes.drive_bit   = in_shift && (strobes.phase == PH_DRIVE);
    assign strobes.sclk_rise   = in_shift && (strobes.phase == PH_RISE);
    assign strobes.sclk_fall   = in_shift && phase_end;
    assign strobes.frame_stop  = (state == STOP);
    assign strobes.clear       = (state == IDLE) || (state == WAIT_FS);

    // bit 0 has nothing to sample yet, tail catches the last one.
    assign strobes.sample_a = (in_shift && strobes.phase == PH_DRIVE && strobes.bit_cnt != '0) ||
                              (in_tail && strobes.phase == PH_DRIVE);
    assign strobes.sample_b = (in_shift && strobes.phase == PH_HIGH && strobes.bit_cnt != '0) ||
                              (in_tail && strobes.phase == PH_HIGH);
    assign strobes.latch    = in_tail && phase_end;

endmodule

// ==== spi_line_driver.sv ====
`timescale 1ns/10ps

module spi_line_driver #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    spi_strobe_if.line       strobes,
    input  logic [WIDTH-1:0] chip_txd,
    output logic             sclk,
    output logic             mosi
);

    logic [WIDTH-1:0] tx_shift;
    logic             line_idle;

    // lines rest low outside the bit times.
    assign line_idle = strobes.clear || strobes.frame_start || strobes.frame_stop;

    // word is taken once per frame.
    always_ff @(posedge clk) begin
        if (strobes.frame_start) begin
            tx_shift <= chip_txd;
        end else if (strobes.drive_bit) begin
            tx_shift <= {tx_shift[WIDTH-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mosi <= 1'b0;
        end else if (line_idle) begin
            mosi <= 1'b0;
        end else if (strobes.drive_bit) begin
            mosi <= tx_shift[WIDTH-1]; // msb first.
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sclk <= 1'b0;
        end else if (line_idle || strobes.sclk_fall) begin
            sclk <= 1'b0;
        end else if (strobes.sclk_rise) begin
            sclk <= 1'b1;
        end
    end

endmodule

// ==== spi_dual_capture.sv ====
`timescale 1ns/10ps

module spi_dual_capture #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    spi_strobe_if.capture    strobes,
    input  logic             idle,
    input  logic             miso,
    output logic [WIDTH-1:0] chip_rxda,
    output logic [WIDTH-1:0] chip_rxdb
);

    logic [WIDTH-1:0] word_a; // sampled in the low half of sclk.
    logic [WIDTH-1:0] word_b; // sampled in the high half.

    always_ff @(posedge clk) begin
        if (strobes.clear) begin
            word_a <= '0;
        end else if (strobes.sample_a) begin
            word_a <= {word_a[WIDTH-2:0], miso};
        end
    end

    always_ff @(posedge clk) begin
        if (strobes.clear) begin
            word_b <= '0;
        end else if (strobes.sample_b) begin
            word_b <= {word_b[WIDTH-2:0], miso};
        end
    end

    // results stay put until the next frame finishes.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            chip_rxda <= '0;
            chip_rxdb <= '0;
        end else if (idle) begin
            chip_rxda <= '0;
            chip_rxdb <= '0;
        end else if (strobes.latch) begin
            chip_rxda <= word_a;
            chip_rxdb <= word_b;
        end
    end

endmodule

// ==== spi_frame_top.sv ====
`timescale 1ns/10ps

module spi_frame_top #(
    parameter int WIDTH      = 16,
    parameter int GAP_CYCLES = 10
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             fs,
    input  logic             miso,
    input  logic [WIDTH-1:0] chip_txd,
    output logic             fd_spi,
    output logic             fd_prd,
    output logic             sclk,
    output logic             mosi,
    output logic             cs,
    output logic [WIDTH-1:0] chip_rxda,
    output logic [WIDTH-1:0] chip_rxdb
);

    logic idle;

    spi_strobe_if #(.WIDTH(WIDTH)) strobes ();

    spi_frame_ctrl #(
        .WIDTH      (WIDTH),
        .GAP_CYCLES (GAP_CYCLES)
    ) spi_frame_ctrl_i (
        .clk     (clk),
        .rst     (rst),
        .fs      (fs),
        .strobes (strobes.ctrl),
        .cs      (cs),
        .fd_spi  (fd_spi),
        .fd_prd  (fd_prd),
        .idle    (idle)
    );

    spi_line_driver #(
        .WIDTH (WIDTH)
    ) spi_line_driver_i (
        .clk      (clk),
        .rst      (rst),
        .strobes  (strobes.line),
        .chip_txd (chip_txd),
        .sclk     (sclk),
        .mosi     (mosi)
    );

    spi_dual_capture #(
        .WIDTH (WIDTH)
    ) spi_dual_capture_i (
        .clk       (clk),
        .rst       (rst),
        .strobes   (strobes.capture),
        .idle      (idle),
        .miso      (miso),
        .chip_rxda (chip_rxda),
        .chip_rxdb (chip_rxdb)
    );

endmodule

// ==== spi_slave_model.sv ====
`timescale 1ns/10ps

module spi_slave_model #(
    parameter int WIDTH = 16
) (
    input  logic             cs,
    input  logic             sclk,
    input  logic             mosi,
    input  logic [WIDTH-1:0] reply,
    output logic             miso
);

    logic [WIDTH-1:0] tx_word;
    logic [WIDTH-1:0] rx_word;  // mosi bits collected in the last frame.
    int               rise_cnt; // sclk rises seen while cs is low.

    initial begin
        miso     = 1'b0;
        tx_word  = '0;
        rx_word  = '0;
        rise_cnt = 0;
    end

    // a falling cs loads the reply and every sclk rise moves one bit each way.
    always @(negedge cs or posedge cs or posedge sclk) begin
        if (cs) begin
            miso = 1'b0;
        end else if (sclk) begin
            rx_word  = {rx_word[WIDTH-2:0], mosi};
            tx_word  = {tx_word[WIDTH-2:0], 1'b0};
            miso     = tx_word[WIDTH-1]; // zeros once the reply runs out.
            rise_cnt = rise_cnt + 1;
        end else begin
            tx_word  = reply;
            miso     = reply[WIDTH-1];
            rx_word  = '0;
            rise_cnt = 0;
        end
    end

endmodule

// ==== spi_frame_tb.sv ====
`timescale 1ns/10ps

module spi_frame_tb
    import spi_frame_pkg::*;
();

    localparam int WIDTH          = 16;
    localparam int GAP_CYCLES     = 10;
    localparam int ROWS           = 6;
    localparam int HOLD_ROW       = 1;  // this row keeps fs high in done.
    localparam int HOLD_EXTRA     = 20;
    localparam int LATCH_AT       = 4 * WIDTH + 5;
    localparam int CS_RISE        = 4 * WIDTH + 6;
    localparam int FRAME_END      = CS_RISE + GAP_CYCLES;
    localparam int TIMEOUT_CYCLES = ROWS * (4 * WIDTH + GAP_CYCLES + 40);

    logic             clk;
    logic             rst;
    logic             fs;
    logic             miso;
    logic [WIDTH-1:0] chip_txd;
    logic             fd_spi;
    logic             fd_prd;
    logic             sclk;
    logic             mosi;
    logic             cs;
    logic [WIDTH-1:0] chip_rxda;
    logic [WIDTH-1:0] chip_rxdb;
    logic [WIDTH-1:0] reply;

    // stimulus table, one frame per row.
    logic [WIDTH-1:0] tbl_txd   [ROWS];
    logic [WIDTH-1:0] tbl_reply [ROWS];
    int               tbl_idle  [ROWS];

    logic [WIDTH-1:0] prev_a;
    logic [WIDTH-1:0] prev_b;
    int               seed;
    int               cycle_cnt = 0;

    spi_frame_top #(
        .WIDTH      (WIDTH),
        .GAP_CYCLES (GAP_CYCLES)
    ) spi_frame_top_i (
        .clk       (clk),
        .rst       (rst),
        .fs        (fs),
        .miso      (miso),
        .chip_txd  (chip_txd),
        .fd_spi    (fd_spi),
        .fd_prd    (fd_prd),
        .sclk      (sclk),
        .mosi      (mosi),
        .cs        (cs),
        .chip_rxda (chip_rxda),
        .chip_rxdb (chip_rxdb)
    );

    spi_slave_model #(
        .WIDTH (WIDTH)
    ) spi_slave_model_i (
        .cs    (cs),
        .sclk  (sclk),
        .mosi  (mosi),
        .reply (reply),
        .miso  (miso)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic report_failure();
        seq_state_t st;
        st = spi_frame_top_i.spi_frame_ctrl_i.state;
        $display("sequencer state %s at %0t", st.name(), $time);
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles", cycle_cnt);
            report_failure();
        end
    end

    task automatic check_word(input string name, input logic [WIDTH-1:0] got,
                              input logic [WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic fill_table();
        tbl_txd[0]   = '1;
        tbl_reply[0] = '1;
        tbl_idle[0]  = 2;
        tbl_txd[1]   = 16'hA55A;
        tbl_reply[1] = 16'h5AA5;
        tbl_idle[1]  = 3;
        for (int r = 2; r < ROWS; r++) begin
            tbl_txd[r]   = WIDTH'($random(seed));
            tbl_reply[r] = WIDTH'($random(seed));
            tbl_idle[r]  = ($random(seed) & 3) + 2;
        end
    endtask

    task automatic check_reset_state();
        check_bit("cs", cs, 1'b1);
        check_bit("sclk", sclk, 1'b0);
        check_bit("mosi", mosi, 1'b0);
        check_bit("fd_spi", fd_spi, 1'b0);
        check_bit("fd_prd", fd_prd, 1'b0);
        check_word("chip_rxda", chip_rxda, '0);
        check_word("chip_rxdb", chip_rxdb, '0);
    endtask

    // k counts edges after the one where fs was first seen high.
    task automatic check_frame_cycle(input int k, input logic [WIDTH-1:0] exp_a,
                                     input logic [WIDTH-1:0] exp_b);
        check_bit("cs", cs, (k >= CS_RISE));
        check_bit("fd_spi", fd_spi, (k >= CS_RISE));
        check_bit("fd_prd", fd_prd, (k >= FRAME_END));
        if (k >= CS_RISE) begin
            check_bit("sclk", sclk, 1'b0);
            check_bit("mosi", mosi, 1'b0);
        end
        check_word("chip_rxda", chip_rxda, (k >= LATCH_AT) ? exp_a : prev_a);
        check_word("chip_rxdb", chip_rxdb, (k >= LATCH_AT) ? exp_b : prev_b);
    endtask

    task automatic run_row(input int row);
        logic [WIDTH-1:0] exp_a;
        logic [WIDTH-1:0] exp_b;
        int               k;
        exp_a = tbl_reply[row] << 1; // the low-phase word misses the first reply bit.
        exp_b = tbl_reply[row] << 2;
        @(posedge clk);
        chip_txd <= tbl_txd[row];
        reply    <= tbl_reply[row];
        repeat (tbl_idle[row]) @(posedge clk);
        fs <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_bit("cs", cs, 1'b1);
        check_bit("fd_prd", fd_prd, 1'b0);
        k = 0;
        do begin
            @(posedge clk);
            if (k == 0) begin
                chip_txd <= ~tbl_txd[row]; // word is latched at this edge.
            end
            k = k + 1;
            @(negedge clk);
            check_frame_cycle(k, exp_a, exp_b);
        end while (fd_prd !== 1'b1);
        check_word("slave rx_word", spi_slave_model_i.rx_word, tbl_txd[row]);
        check_word("sclk rise count", WIDTH'(spi_slave_model_i.rise_cnt), WIDTH'(WIDTH));
        if (row == HOLD_ROW) begin
            repeat (HOLD_EXTRA) begin
                @(posedge clk);
                @(negedge clk);
                check_bit("fd_prd", fd_prd, 1'b1);
                check_bit("fd_spi", fd_spi, 1'b0);
                check_bit("cs", cs, 1'b1);
                check_bit("sclk", sclk, 1'b0);
            end
        end
        @(posedge clk);
        fs <= 1'b0;
        @(negedge clk);
        check_bit("fd_prd", fd_prd, 1'b1); // low fs is seen one edge later.
        check_bit("fd_spi", fd_spi, 1'b0);
        @(posedge clk);
        @(negedge clk);
        check_bit("fd_prd", fd_prd, 1'b0);
        check_bit("fd_spi", fd_spi, 1'b0);
        check_word("chip_rxda", chip_rxda, exp_a);
        check_word("chip_rxdb", chip_rxdb, exp_b);
        prev_a = exp_a;
        prev_b = exp_b;
    endtask

    initial begin
        seed = 71;
        rst      <= 1'b1;
        fs       <= 1'b0;
        chip_txd <= '0;
        reply    <= '0;
        prev_a = '0;
        prev_b = '0;
        fill_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_reset_state();
        for (int r = 0; r < ROWS; r++) begin
            run_row(r);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== files.f ====
spi_frame_pkg.sv
spi_strobe_if.sv
spi_frame_ctrl.sv
spi_line_driver.sv
spi_dual_capture.sv
spi_frame_top.sv
spi_slave_model.sv
spi_frame_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the spi frame testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module spi_frame_tb -f files.f -o spi_frame_sim
if [ $? -ne 0 ]; then
    echo "verilator build did not complete"
    exit 1
fi

./obj_dir/spi_frame_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
    echo "simulation FAILED"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

echo "simulation PASSED"
exit 0
